//--- logic/dcache_pkg.sv
package dcache_pkg;

    localparam int CL_SIZE      = 32;
    localparam int OOO_TAG_SIZE = 4;
    localparam int IDX_CNT      = 16;
    localparam int FILL_Q_DEPTH = 4;

    typedef logic [31:0]             addr_t;
    typedef logic [CL_SIZE-1:0]      line_t;
    typedef logic [2:0]              op_t;
    typedef logic [OOO_TAG_SIZE-1:0] ooo_tag_t;

    // Address split: tag 31..6, index 5..2, byte 1..0
    typedef logic [3:0]  idx_t;
    typedef logic [25:0] ctag_t;

    typedef enum logic {
        BANK_RUN,
        BANK_HOLD
    } bank_state_t;

    localparam op_t OP_NOP = 3'd0;
    localparam op_t OP_LD  = 3'd1;
    localparam op_t OP_ST  = 3'd2;
    localparam op_t OP_RD  = 3'd3;
    localparam op_t OP_WR  = 3'd4;
    localparam op_t OP_UPD = 3'd6;

endpackage

//--- logic/fill_queue.sv
`timescale 1ns/1ps

module fill_queue (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              fill_alloc,
    input  dcache_pkg::addr_t fill_addr,
    input  dcache_pkg::line_t fill_data,
    input  logic              head_dealloc,
    output logic              fill_full,
    output logic              head_valid,
    output dcache_pkg::addr_t head_addr,
    output dcache_pkg::line_t head_data
);
    import dcache_pkg::*;

    addr_t addr_mem [FILL_Q_DEPTH];
    line_t data_mem [FILL_Q_DEPTH];

    logic [$clog2(FILL_Q_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FILL_Q_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FILL_Q_DEPTH):0]   count;

    logic push;
    logic pop;

    // Extra alloc while full is dropped
    assign push = fill_alloc && !fill_full;
    assign pop  = head_dealloc && head_valid;

    assign fill_full  = (count == ($clog2(FILL_Q_DEPTH) + 1)'(FILL_Q_DEPTH));
    assign head_valid = (count != '0);
    assign head_addr  = addr_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= fill_addr;
            data_mem[wr_ptr] <= fill_data;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/queue_arbiter.sv
`timescale 1ns/1ps

module queue_arbiter (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 head_valid,
    input  dcache_pkg::addr_t    head_addr,
    input  dcache_pkg::line_t    head_data,
    input  logic                 pipe_valid,
    input  dcache_pkg::addr_t    pipe_addr,
    input  dcache_pkg::line_t    pipe_data,
    input  dcache_pkg::op_t      pipe_op,
    input  dcache_pkg::ooo_tag_t pipe_tag,
    input  logic                 stall_cache,
    output logic                 head_dealloc,
    output logic                 pipe_ready,
    output logic                 req_valid,
    output dcache_pkg::addr_t    req_addr,
    output dcache_pkg::line_t    req_data,
    output dcache_pkg::op_t      req_op,
    output dcache_pkg::ooo_tag_t req_tag
);
    import dcache_pkg::*;

    logic active;
    logic take_fill;
    logic take_pipe;

    // Fill head always wins over the pipeline
    assign take_fill    = active && !stall_cache && head_valid;
    assign pipe_ready   = active && !stall_cache && !head_valid;
    assign take_pipe    = pipe_ready && pipe_valid;
    assign head_dealloc = take_fill;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (!stall_cache) begin
                req_valid <= take_fill || take_pipe;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_fill) begin
            req_addr <= head_addr;
            req_data <= head_data;
            req_op   <= OP_UPD;
            req_tag  <= '0;
        end else if (take_pipe) begin
            req_addr <= pipe_addr;
            req_data <= pipe_data;
            req_op   <= pipe_op;
            req_tag  <= pipe_tag;
        end else if (!stall_cache) begin
            req_op <= OP_NOP;
        end
    end

endmodule

//--- logic/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  dcache_pkg::addr_t    req_addr,
    input  dcache_pkg::line_t    req_data,
    input  dcache_pkg::op_t      req_op,
    input  dcache_pkg::ooo_tag_t req_tag,
    input  logic                 miss_full,
    output logic                 stall_cache,
    output logic                 resp_valid,
    output logic                 resp_hit,
    output dcache_pkg::addr_t    resp_addr,
    output dcache_pkg::line_t    resp_data,
    output dcache_pkg::op_t      resp_op,
    output dcache_pkg::ooo_tag_t resp_tag,
    output logic                 miss_alloc,
    output dcache_pkg::addr_t    miss_addr,
    output dcache_pkg::line_t    miss_data,
    output dcache_pkg::op_t      miss_op
);
    import dcache_pkg::*;

    logic [IDX_CNT-1:0] line_valid;
    ctag_t              tag_mem [IDX_CNT];
    line_t              data_mem [IDX_CNT];

    bank_state_t state;
    bank_state_t state_nxt;

    idx_t  req_idx;
    ctag_t req_ctag;
    logic  is_ld;
    logic  is_st;
    logic  is_fill;
    logic  hit;
    logic  out_load;
    logic  out_valid_q;
    logic  out_miss_q;

    assign req_idx  = req_addr[5:2];
    assign req_ctag = req_addr[31:6];
    assign is_ld    = req_valid && (req_op == OP_LD);
    assign is_st    = req_valid && (req_op == OP_ST);
    assign is_fill  = req_valid && (req_op == OP_UPD);
    assign hit      = line_valid[req_idx] && (tag_mem[req_idx] == req_ctag);

    // Output stage is frozen while a miss waits for room downstream
    always_comb begin
        state_nxt = state;
        out_load  = 1'b1;
        case (state)
            BANK_RUN: begin
                if (out_miss_q && miss_full) begin
                    state_nxt = BANK_HOLD;
                    out_load  = 1'b0;
                end
            end
            BANK_HOLD: begin
                if (miss_full) begin
                    out_load = 1'b0;
                end else begin
                    state_nxt = BANK_RUN;
                end
            end
            default: state_nxt = BANK_RUN;
        endcase
    end

    assign stall_cache = !out_load;
    assign resp_valid  = out_valid_q && out_load;
    assign miss_alloc  = out_miss_q && out_load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= BANK_RUN;
            out_valid_q <= 1'b0;
            out_miss_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (out_load) begin
                out_valid_q <= is_ld || is_st;
                out_miss_q  <= (is_ld || is_st) && !hit;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (out_load && is_fill) begin
            line_valid[req_idx] <= 1'b1;
        end
    end

    // Fill replaces the line, store hit only the data
    always_ff @(posedge clk) begin
        if (out_load && is_fill) begin
            tag_mem[req_idx]  <= req_ctag;
            data_mem[req_idx] <= req_data;
        end else if (out_load && is_st && hit) begin
            data_mem[req_idx] <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            resp_hit  <= hit;
            resp_addr <= req_addr;
            resp_data <= is_st ? req_data : (hit ? data_mem[req_idx] : '0);
            resp_op   <= req_op;
            resp_tag  <= req_tag;
            // Store misses go out as writes with their data
            miss_addr <= req_addr;
            miss_data <= is_st ? req_data : '0;
            miss_op   <= is_st ? OP_WR : OP_RD;
        end
    end

endmodule

//--- logic/dcache_core.sv
`timescale 1ns/1ps

module dcache_core (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 pipe_valid,
    input  dcache_pkg::addr_t    pipe_addr,
    input  dcache_pkg::line_t    pipe_data,
    input  dcache_pkg::op_t      pipe_op,
    input  dcache_pkg::ooo_tag_t pipe_tag,
    output logic                 pipe_ready,

    input  logic                 fill_alloc,
    input  dcache_pkg::addr_t    fill_addr,
    input  dcache_pkg::line_t    fill_data,
    output logic                 fill_full,

    output logic                 resp_valid,
    output logic                 resp_hit,
    output dcache_pkg::addr_t    resp_addr,
    output dcache_pkg::line_t    resp_data,
    output dcache_pkg::op_t      resp_op,
    output dcache_pkg::ooo_tag_t resp_tag,

    output logic                 miss_alloc,
    output dcache_pkg::addr_t    miss_addr,
    output dcache_pkg::line_t    miss_data,
    output dcache_pkg::op_t      miss_op,
    input  logic                 miss_full
);
    import dcache_pkg::*;

    // Fill queue head
    logic     head_valid;
    addr_t    head_addr;
    line_t    head_data;
    logic     head_dealloc;

    // Registered request into the bank
    logic     req_valid;
    addr_t    req_addr;
    line_t    req_data;
    op_t      req_op;
    ooo_tag_t req_tag;
    logic     stall_cache;

    fill_queue i_fill_queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .fill_alloc   (fill_alloc),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .head_dealloc (head_dealloc),
        .fill_full    (fill_full),
        .head_valid   (head_valid),
        .head_addr    (head_addr),
        .head_data    (head_data)
    );

    queue_arbiter i_queue_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .head_valid   (head_valid),
        .head_addr    (head_addr),
        .head_data    (head_data),
        .pipe_valid   (pipe_valid),
        .pipe_addr    (pipe_addr),
        .pipe_data    (pipe_data),
        .pipe_op      (pipe_op),
        .pipe_tag     (pipe_tag),
        .stall_cache  (stall_cache),
        .head_dealloc (head_dealloc),
        .pipe_ready   (pipe_ready),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_data     (req_data),
        .req_op       (req_op),
        .req_tag      (req_tag)
    );

    cache_bank i_cache_bank (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_data     (req_data),
        .req_op       (req_op),
        .req_tag      (req_tag),
        .miss_full    (miss_full),
        .stall_cache  (stall_cache),
        .resp_valid   (resp_valid),
        .resp_hit     (resp_hit),
        .resp_addr    (resp_addr),
        .resp_data    (resp_data),
        .resp_op      (resp_op),
        .resp_tag     (resp_tag),
        .miss_alloc   (miss_alloc),
        .miss_addr    (miss_addr),
        .miss_data    (miss_data),
        .miss_op      (miss_op)
    );

endmodule

//--- bench/dcache_core_checker.sv
`timescale 1ns/1ps

module dcache_core_checker (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pipe_valid,
    input  logic                 pipe_ready,
    input  dcache_pkg::addr_t    pipe_addr,
    input  dcache_pkg::line_t    pipe_data,
    input  dcache_pkg::op_t      pipe_op,
    input  dcache_pkg::ooo_tag_t pipe_tag,
    input  logic                 fill_alloc,
    input  logic                 fill_full,
    input  dcache_pkg::addr_t    fill_addr,
    input  dcache_pkg::line_t    fill_data,
    input  logic                 resp_valid,
    input  logic                 resp_hit,
    input  dcache_pkg::addr_t    resp_addr,
    input  dcache_pkg::line_t    resp_data,
    input  dcache_pkg::op_t      resp_op,
    input  dcache_pkg::ooo_tag_t resp_tag,
    input  logic                 miss_alloc,
    input  dcache_pkg::addr_t    miss_addr,
    input  dcache_pkg::line_t    miss_data,
    input  dcache_pkg::op_t      miss_op,
    input  logic                 miss_full,
    output int                   mismatches,
    output int                   failures,
    output int                   pending
);
    import dcache_pkg::*;

    // Reference copy of the 16 lines
    logic  ref_valid [16];
    ctag_t ref_tag [16];
    line_t ref_data [16];

    // Expected responses, in request order
    logic     exp_hit [$];
    addr_t    exp_addr [$];
    op_t      exp_op [$];
    ooo_tag_t exp_tag [$];
    line_t    exp_data [$];
    logic     exp_chk_data [$];
    int       exp_cycle [$];

    // Expected miss requests
    addr_t mq_addr [$];
    op_t   mq_op [$];
    line_t mq_data [$];

    int cycle;
    int last_full;
    int q_count;
    logic stalled;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s expected 0x%08h got 0x%08h",
                     $time, name, exp, got);
        end
    endtask

    task automatic predict_pipe();
        idx_t idx;
        logic hit;
        idx = pipe_addr[5:2];
        hit = ref_valid[idx] && (ref_tag[idx] == pipe_addr[31:6]);
        exp_hit.push_back(hit);
        exp_addr.push_back(pipe_addr);
        exp_op.push_back(pipe_op);
        exp_tag.push_back(pipe_tag);
        exp_data.push_back(ref_data[idx]);
        exp_chk_data.push_back(hit && (pipe_op == OP_LD));
        exp_cycle.push_back(cycle);
        if (pipe_op == OP_ST && hit) begin
            ref_data[idx] = pipe_data;
        end
        if (!hit) begin
            mq_addr.push_back(pipe_addr);
            mq_op.push_back(pipe_op == OP_ST ? OP_WR : OP_RD);
            mq_data.push_back(pipe_data);
        end
    endtask

    task automatic check_resp();
        int acc;
        if (exp_addr.size() == 0) begin
            failures++;
            $display("Unexpected response at %0t ns with no request outstanding", $time);
        end else begin
            acc = exp_cycle.pop_front();
            check_field("resp_hit", 32'(exp_hit.pop_front()), 32'(resp_hit));
            check_field("resp_addr", exp_addr.pop_front(), resp_addr);
            check_field("resp_op", 32'(exp_op.pop_front()), 32'(resp_op));
            check_field("resp_tag", 32'(exp_tag.pop_front()), 32'(resp_tag));
            if (exp_chk_data.pop_front()) begin
                check_field("resp_data", exp_data.pop_front(), resp_data);
            end else begin
                void'(exp_data.pop_front());
            end
            // Latency is only fixed when no back-pressure was seen
            if (last_full < acc && cycle - acc != 2) begin
                failures++;
                $display("Response at %0t ns came %0d cycles after accept instead of 2",
                         $time, cycle - acc);
            end
        end
    endtask

    task automatic check_miss();
        op_t op;
        line_t data;
        if (mq_addr.size() == 0) begin
            failures++;
            $display("Unexpected miss request at %0t ns", $time);
        end else begin
            op = mq_op.pop_front();
            data = mq_data.pop_front();
            check_field("miss_addr", mq_addr.pop_front(), miss_addr);
            check_field("miss_op", 32'(op), 32'(miss_op));
            if (op == OP_WR) begin
                check_field("miss_data", data, miss_data);
            end
        end
    endtask

    initial begin
        mismatches = 0;
        failures   = 0;
        pending    = 0;
        cycle      = 0;
        last_full  = -100;
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                ref_valid[i] = 1'b0;
                ref_tag[i]   = '0;
                ref_data[i]  = '0;
            end
            q_count = 0;
        end else begin
            cycle++;
            if (miss_full) begin
                last_full = cycle;
            end
            // Oldest response is a miss held at the bank output
            stalled = 1'b0;
            if (exp_addr.size() != 0) begin
                stalled = !exp_hit[0] && miss_full && (cycle - exp_cycle[0] >= 2);
            end
            if (stalled) begin
                check_field("resp_valid", 32'd0, 32'(resp_valid));
            end
            if (stalled || q_count != 0) begin
                check_field("pipe_ready", 32'd0, 32'(pipe_ready));
            end
            // Fill queue holds four entries
            check_field("fill_full", 32'(q_count == 4), 32'(fill_full));
            if (miss_alloc && miss_full) begin
                failures++;
                $display("Miss request at %0t ns was issued while miss_full was high", $time);
            end
            if (resp_valid) begin
                check_resp();
            end
            if (miss_alloc) begin
                check_miss();
            end
            // Pipeline accept comes before a fill pushed at the same edge
            if (pipe_valid && pipe_ready) begin
                predict_pipe();
            end
            // One fill leaves the queue per cycle unless the bank stalls
            if (!stalled && q_count != 0) begin
                q_count--;
            end
            if (fill_alloc && !fill_full) begin
                ref_valid[fill_addr[5:2]] = 1'b1;
                ref_tag[fill_addr[5:2]]   = fill_addr[31:6];
                ref_data[fill_addr[5:2]]  = fill_data;
                q_count++;
            end
            pending = exp_addr.size() + mq_addr.size();
        end
    end

endmodule

//--- bench/dcache_core_tb.sv
`timescale 1ns/1ps

module dcache_core_tb;
    import dcache_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 500;
    localparam int KIND_PIPE   = 0;
    localparam int KIND_FILL   = 1;
    localparam int KIND_WINDOW = 2;

    logic     clk;
    logic     arst_n;
    logic     pipe_valid;
    addr_t    pipe_addr;
    line_t    pipe_data;
    op_t      pipe_op;
    ooo_tag_t pipe_tag;
    logic     pipe_ready;
    logic     fill_alloc;
    addr_t    fill_addr;
    line_t    fill_data;
    logic     fill_full;
    logic     resp_valid;
    logic     resp_hit;
    addr_t    resp_addr;
    line_t    resp_data;
    op_t      resp_op;
    ooo_tag_t resp_tag;
    logic     miss_alloc;
    addr_t    miss_addr;
    line_t    miss_data;
    op_t      miss_op;
    logic     miss_full;

    int mismatches;
    int failures;
    int pending;
    int tb_errors;
    int full_waits;
    int window_req;
    int window_left;
    logic timed_out;

    // Stimulus table
    int       row_kind [$];
    op_t      row_op [$];
    addr_t    row_addr [$];
    line_t    row_data [$];
    ooo_tag_t row_tag [$];
    int       row_len [$];

    dcache_core i_dut (.*);

    dcache_core_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Owns miss_full so windows overlap the following rows
    always @(negedge clk) begin
        if (window_req != 0) begin
            window_left = window_req;
            window_req  = 0;
        end else if (window_left != 0) begin
            window_left = window_left - 1;
        end
        miss_full = (window_left != 0);
    end

    task automatic add_row(input int kind, input op_t op, input addr_t addr,
                           input line_t data, input ooo_tag_t tag, input int len);
        row_kind.push_back(kind);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_tag.push_back(tag);
        row_len.push_back(len);
    endtask

    task automatic build_table();
        add_row(KIND_PIPE, OP_LD, 32'h0000_0100, '0, 4'd1, 0);
        add_row(KIND_FILL, OP_NOP, 32'h0000_0100, 32'hAAAA_0001, '0, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0100, '0, 4'd2, 0);
        add_row(KIND_PIPE, OP_ST, 32'h0000_0100, 32'h5555_1234, 4'd3, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0100, '0, 4'd4, 0);
        add_row(KIND_PIPE, OP_ST, 32'h0000_0204, 32'h7777_0042, 4'd5, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0204, '0, 4'd6, 0);
        // Same index as 0x100, different tag
        add_row(KIND_FILL, OP_NOP, 32'h0000_0140, 32'hBBBB_0002, '0, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0100, '0, 4'd7, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0140, '0, 4'd8, 0);
        add_row(KIND_WINDOW, OP_NOP, '0, '0, '0, 20);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0308, '0, 4'd9, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_030C, '0, 4'd10, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0140, '0, 4'd11, 0);
        add_row(KIND_PIPE, OP_ST, 32'h0000_0310, 32'h0BAD_F00D, 4'd12, 0);
        add_row(KIND_PIPE, OP_LD, 32'h0000_0400, '0, 4'd13, 0);
        // Five fills behind a stalled miss
        add_row(KIND_WINDOW, OP_NOP, '0, '0, '0, 30);
        for (int i = 0; i < 5; i++) begin
            add_row(KIND_FILL, OP_NOP, 32'h0000_0400 + 32'(4 * i), 32'hC0C0_0000 + 32'(i), '0, 0);
        end
        for (int i = 0; i < 5; i++) begin
            add_row(KIND_PIPE, OP_LD, 32'h0000_0400 + 32'(4 * i), '0, 4'(i), 0);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        tb_errors++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic issue_pipe_op(input int r);
        int n;
        logic accepted;
        repeat ($urandom_range(0, 2)) @(negedge clk);
        pipe_valid = 1'b1;
        pipe_addr  = row_addr[r];
        pipe_data  = row_data[r];
        pipe_op    = row_op[r];
        pipe_tag   = row_tag[r];
        n = 0;
        accepted = 1'b0;
        while (!accepted && n < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = pipe_ready;
            @(negedge clk);
            n++;
        end
        pipe_valid = 1'b0;
        if (!accepted) begin
            note_timeout("pipe_ready");
        end
    endtask

    task automatic push_fill(input int r);
        int n;
        n = 0;
        if (fill_full) begin
            full_waits++;
        end
        while (fill_full && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (fill_full) begin
            note_timeout("fill_full to drop");
        end else begin
            fill_alloc = 1'b1;
            fill_addr  = row_addr[r];
            fill_data  = row_data[r];
            @(negedge clk);
            fill_alloc = 1'b0;
        end
    endtask

    task automatic start_window(input int r);
        @(posedge clk);
        window_req = row_len[r];
        @(negedge clk);
    endtask

    initial begin
        int n;
        arst_n      = 1'b0;
        pipe_valid  = 1'b0;
        pipe_addr   = '0;
        pipe_data   = '0;
        pipe_op     = OP_NOP;
        pipe_tag    = '0;
        fill_alloc  = 1'b0;
        fill_addr   = '0;
        fill_data   = '0;
        miss_full   = 1'b0;
        window_req  = 0;
        window_left = 0;
        tb_errors   = 0;
        full_waits  = 0;
        timed_out   = 1'b0;
        void'($urandom(70586));
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int r = 0; r < row_kind.size() && !timed_out; r++) begin
            case (row_kind[r])
                KIND_PIPE: issue_pipe_op(r);
                KIND_FILL: push_fill(r);
                default:   start_window(r);
            endcase
        end

        n = 0;
        while (!timed_out && (pending != 0 || window_left != 0) && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && pending != 0) begin
            tb_errors++;
            $display("%0d responses or miss requests never appeared", pending);
        end
        if (full_waits == 0) begin
            tb_errors++;
            $display("fill_full never rose during the fill burst");
        end
        repeat (4) @(negedge clk);

        $display("Error counts: mismatches %0d, other errors %0d",
                 mismatches, failures + tb_errors);
        if (mismatches + failures + tb_errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dcache_core.f
logic/dcache_pkg.sv
logic/fill_queue.sv
logic/queue_arbiter.sv
logic/cache_bank.sv
logic/dcache_core.sv
bench/dcache_core_checker.sv
bench/dcache_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dcache_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -sv --top-module dcache_core_tb -f dcache_core.f \
    -o sim_dcache_core > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_dcache_core > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -q "^Finished with no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
